//--- files.f
rtl/io_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/perf_counters.sv
rtl/io.sv
test/tb_clock.sv
test/io_checker.sv
test/io_tb.sv

//--- rtl/io.sv
`timescale 1ns/1ps

module io
    import io_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  io_req_t      req,
    input  core_events_t events,
    input  logic         serial_in,
    output logic         serial_out,
    output logic [31:0]  dout
);

    // uart transmit side
    logic [7:0]   tx_data;
    logic         tx_valid;
    logic         tx_ready;
    logic         tx_load;

    // uart receive side
    logic [7:0]   rx_data;
    logic         rx_valid;
    logic         rx_ready;
    logic         rx_ack;

    // counters
    logic         clear;
    logic [31:0]  cycle_cnt;
    logic [31:0]  inst_cnt;
    logic [31:0]  br_inst_cnt;
    logic [31:0]  br_suc_cnt;

    uart_status_t status;
    logic [31:0]  rd_data;

    assign status.rx_valid = rx_valid;
    assign status.tx_ready = tx_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // peripherals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    uart_tx u_uart_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx u_uart_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .serial_in (serial_in),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready)
    );

    perf_counters u_perf_counters (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (clear),
        .events      (events),
        .cycle_cnt   (cycle_cnt),
        .inst_cnt    (inst_cnt),
        .br_inst_cnt (br_inst_cnt),
        .br_suc_cnt  (br_suc_cnt)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_data = '0; // unmapped and write-only give zero.
        rx_ack  = 1'b0;
        tx_load = 1'b0;
        clear   = 1'b0;
        if (req.en) begin
            case (req.addr)
                ADDR_UART_CTRL:   rd_data = {30'b0, status};
                ADDR_UART_RDATA: begin
                    rd_data = {24'b0, rx_data};
                    rx_ack  = 1'b1;
                end
                ADDR_UART_TDATA:  tx_load = tx_ready; // dropped while busy.
                ADDR_CYCLE_CNT:   rd_data = cycle_cnt;
                ADDR_INST_CNT:    rd_data = inst_cnt;
                ADDR_RST_CNT:     clear = 1'b1; // counters zero after this edge.
                ADDR_BR_INST_CNT: rd_data = br_inst_cnt;
                ADDR_BR_SUC_CNT:  rd_data = br_suc_cnt;
                default: ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registered read data and uart handshakes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout     <= '0;
            tx_valid <= 1'b0;
            rx_ready <= 1'b0;
        end else begin
            dout     <= rd_data;
            rx_ready <= rx_ack; // one cycle ack.
            if (tx_load) begin
                tx_valid <= 1'b1;
            end else if (tx_valid && tx_ready) begin
                tx_valid <= 1'b0; // byte handed over.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_data <= req.wdata[7:0];
        end
    end

endmodule

//--- rtl/io_pkg.sv
package io_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory-mapped register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [31:0] ADDR_UART_CTRL   = 32'h8000_0000; // status, read only.
    localparam logic [31:0] ADDR_UART_RDATA  = 32'h8000_0004;
    localparam logic [31:0] ADDR_UART_TDATA  = 32'h8000_0008;
    localparam logic [31:0] ADDR_CYCLE_CNT   = 32'h8000_000C;
    localparam logic [31:0] ADDR_INST_CNT    = 32'h8000_0010;
    localparam logic [31:0] ADDR_RST_CNT     = 32'h8000_0014; // any access clears.
    localparam logic [31:0] ADDR_BR_INST_CNT = 32'h8000_0018;
    localparam logic [31:0] ADDR_BR_SUC_CNT  = 32'h8000_001C;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // uart timing and framing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int CYCLES_PER_BIT = 16;
    localparam int HALF_BIT       = CYCLES_PER_BIT / 2; // start bit mid point.
    localparam int BIT_CNT_W      = 5;
    localparam int DATA_BITS      = 8;
    localparam int FRAME_BITS     = DATA_BITS + 2; // start + data + stop.
    localparam int BIT_IDX_W      = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // core side bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
        logic [31:0] wdata;
    } io_req_t;

    typedef struct packed {
        logic inst_retired;
        logic br_inst;
        logic br_suc; // predicted branch was right.
    } core_events_t;

    // low two bits of the ctrl register
    typedef struct packed {
        logic rx_valid;
        logic tx_ready;
    } uart_status_t;

endpackage

//--- rtl/perf_counters.sv
`timescale 1ns/1ps

module perf_counters
    import io_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         clear,
    input  core_events_t events,
    output logic [31:0]  cycle_cnt,
    output logic [31:0]  inst_cnt,
    output logic [31:0]  br_inst_cnt,
    output logic [31:0]  br_suc_cnt
);

    logic [31:0] cycle_next;
    logic [31:0] inst_next;
    logic [31:0] br_inst_next;
    logic [31:0] br_suc_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next values, all counters wrap at 2^32
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cycle_next   = cycle_cnt + 32'd1;
        inst_next    = inst_cnt + 32'(events.inst_retired);
        br_inst_next = br_inst_cnt + 32'(events.br_inst);
        br_suc_next  = br_suc_cnt + 32'(events.br_suc);
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            // events on a clearing edge are lost.
            cycle_cnt   <= '0;
            inst_cnt    <= '0;
            br_inst_cnt <= '0;
            br_suc_cnt  <= '0;
        end else begin
            cycle_cnt   <= cycle_next;
            inst_cnt    <= inst_next;
            br_inst_cnt <= br_inst_next;
            br_suc_cnt  <= br_suc_next;
        end
    end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import io_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       serial_in,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  logic       rx_ready
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state_q;
    logic [1:0]           sync_q;
    logic                 line;
    logic [BIT_CNT_W-1:0] tick_q;
    logic [BIT_IDX_W-1:0] bit_q;
    logic [DATA_BITS-1:0] shift_q;
    logic                 half_end;
    logic                 bit_end;
    logic                 sample;

    assign line     = sync_q[1];
    assign half_end = (tick_q == BIT_CNT_W'(HALF_BIT - 1));
    assign bit_end  = (tick_q == BIT_CNT_W'(CYCLES_PER_BIT - 1));
    assign sample   = (state_q == RX_DATA) && bit_end;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // synchronizer, bit timing and held byte
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q   <= 2'b11; // line idles high.
            state_q  <= RX_IDLE;
            tick_q   <= '0;
            bit_q    <= '0;
            rx_data  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], serial_in};
            if (rx_ready) begin
                rx_valid <= 1'b0; // taken by io.
            end
            case (state_q)
                RX_IDLE: begin
                    tick_q <= '0;
                    if (!line) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        tick_q  <= '0;
                        bit_q   <= '0;
                        state_q <= line ? RX_IDLE : RX_DATA; // glitch rejected.
                    end else begin
                        tick_q <= tick_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        tick_q <= '0;
                        if (bit_q == BIT_IDX_W'(DATA_BITS - 1)) begin
                            state_q <= RX_STOP;
                        end else begin
                            bit_q <= bit_q + 1'b1;
                        end
                    end else begin
                        tick_q <= tick_q + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        tick_q  <= '0;
                        state_q <= RX_IDLE;
                        if (line) begin
                            // a new byte wins over a pending ack.
                            rx_data  <= shift_q;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        tick_q <= tick_q + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            shift_q <= {line, shift_q[DATA_BITS-1:1]}; // lsb arrives first.
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import io_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       serial_out
);

    logic [FRAME_BITS-1:0] shift_q;
    logic [BIT_CNT_W-1:0]  tick_q;
    logic [BIT_IDX_W-1:0]  bit_q;
    logic                  busy_q;
    logic                  bit_end;
    logic                  last_bit;

    assign bit_end    = (tick_q == BIT_CNT_W'(CYCLES_PER_BIT - 1));
    assign last_bit   = (bit_q == BIT_IDX_W'(FRAME_BITS - 1));
    assign tx_ready   = ~busy_q;     // idle line only.
    assign serial_out = shift_q[0];  // lsb goes out first.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q <= '1;
            tick_q  <= '0;
            bit_q   <= '0;
            busy_q  <= 1'b0;
        end else if (!busy_q) begin
            if (tx_valid) begin
                // stop, data, start.
                shift_q <= {1'b1, tx_data, 1'b0};
                tick_q  <= '0;
                bit_q   <= '0;
                busy_q  <= 1'b1;
            end
        end else if (bit_end) begin
            tick_q  <= '0;
            shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]}; // refill with idle.
            if (last_bit) begin
                busy_q <= 1'b0;
            end else begin
                bit_q <= bit_q + 1'b1;
            end
        end else begin
            tick_q <= tick_q + 1'b1;
        end
    end

endmodule

//--- test/io_checker.sv
`timescale 1ns/1ps

module io_checker
    import io_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input io_req_t     req,
    input logic [31:0] dout,
    input logic        serial_out,
    input logic        tx_ready,
    input logic        rx_valid,
    input logic        rx_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus and uart protocol rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    idle_bus_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !req.en |=> (dout == 32'd0)
    ) else $error("dout not zero after a cycle with no request");

    idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_ready |-> serial_out
    ) else $error("serial_out low while the transmitter is idle");

    // held byte only leaves on an ack.
    rx_valid_needs_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(rx_valid) |-> $past(rx_ready)
    ) else $error("rx_valid dropped without rx_ready on the edge before");

endmodule

//--- test/io_tb.sv
`timescale 1ns/1ps

module io_tb
    import io_pkg::*;
();

    typedef enum logic [2:0] {
        OP_READ,
        OP_WRITE_TX,
        OP_CLEAR,
        OP_EVENTS,
        OP_WAIT_RX,
        OP_CYCLE,
        OP_IDLE
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] arg;       // byte, cycle count or edge distance.
        logic [31:0] expected;
        logic        use_model; // expected comes from the counter model.
    } step_t;

    logic         clk;
    logic         rst_n;
    io_req_t      req;
    core_events_t events;
    logic         serial_line;
    logic [31:0]  dout;

    step_t        steps[$];
    int           cycle_limit = 0;
    int           cycle_count = 0;
    int           error_count = 0;
    logic [31:0]  model_cycles;
    logic [31:0]  model_inst;
    logic [31:0]  model_br_inst;
    logic [31:0]  model_br_suc;

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    io uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .events     (events),
        .serial_in  (serial_line),
        .serial_out (serial_line), // loopback.
        .dout       (dout)
    );

    bind io io_checker u_io_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .dout       (dout),
        .serial_out (serial_out),
        .tx_ready   (tx_ready),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic void add_step(op_t op, logic [31:0] addr, logic [31:0] arg,
                                     logic [31:0] expected, logic use_model);
        step_t s;
        s.op        = op;
        s.addr      = addr;
        s.arg       = arg;
        s.expected  = expected;
        s.use_model = use_model;
        steps.push_back(s);
    endfunction

    // one edge; model follows what was driven into it.
    task automatic tick();
        @(posedge clk);
        if (req.en && req.addr == ADDR_RST_CNT) begin
            model_cycles  = '0;
            model_inst    = '0;
            model_br_inst = '0;
            model_br_suc  = '0;
        end else begin
            model_cycles  = model_cycles + 32'd1;
            model_inst    = model_inst + 32'(events.inst_retired);
            model_br_inst = model_br_inst + 32'(events.br_inst);
            model_br_suc  = model_br_suc + 32'(events.br_suc);
        end
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("Mismatch at %0t ns: %s got 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic access(input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
        req.en    = 1'b1;
        req.addr  = addr;
        req.wdata = wdata;
        tick();
        rdata = dout; // result of the edge just taken.
        req   = '0;
    endtask

    function automatic logic [31:0] model_value(input logic [31:0] addr);
        case (addr)
            ADDR_CYCLE_CNT:   return model_cycles;
            ADDR_INST_CNT:    return model_inst;
            ADDR_BR_INST_CNT: return model_br_inst;
            ADDR_BR_SUC_CNT:  return model_br_suc;
            default:          return 32'd0;
        endcase
    endfunction

    task automatic poll_ctrl_bit(input int bit_idx);
        logic [31:0] status;
        status = '0;
        while (!status[bit_idx]) begin
            access(ADDR_UART_CTRL, 32'd0, status);
        end
    endtask

    function automatic int worst_cycles(input step_t s);
        case (s.op)
            OP_WRITE_TX:        return CYCLES_PER_BIT + 1; // tail of the previous frame.
            OP_WAIT_RX:         return 12 * CYCLES_PER_BIT + 3;
            OP_EVENTS, OP_IDLE: return int'(s.arg);
            OP_CYCLE:           return int'(s.arg) + 1;
            default:            return 1;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        add_step(OP_READ, ADDR_CYCLE_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_INST_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_BR_INST_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_BR_SUC_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_UART_CTRL, 0, 32'h1, 1'b0);  // tx ready, rx empty.
        add_step(OP_READ, ADDR_UART_RDATA, 0, 32'h0, 1'b0);
        add_step(OP_WRITE_TX, ADDR_UART_TDATA, 32'h00, 0, 1'b0);
        add_step(OP_WAIT_RX, ADDR_UART_RDATA, 0, 32'h00, 1'b0);
        add_step(OP_WRITE_TX, ADDR_UART_TDATA, 32'hFF, 0, 1'b0);
        add_step(OP_WAIT_RX, ADDR_UART_RDATA, 0, 32'hFF, 1'b0);
        add_step(OP_WRITE_TX, ADDR_UART_TDATA, 32'h55, 0, 1'b0);
        add_step(OP_WAIT_RX, ADDR_UART_RDATA, 0, 32'h55, 1'b0);
        add_step(OP_WRITE_TX, ADDR_UART_TDATA, 32'hA3, 0, 1'b0);
        add_step(OP_WAIT_RX, ADDR_UART_RDATA, 0, 32'hA3, 1'b0);
        add_step(OP_CYCLE, ADDR_CYCLE_CNT, 1, 0, 1'b0);      // n edges gives n-1.
        add_step(OP_CYCLE, ADDR_CYCLE_CNT, 2, 1, 1'b0);
        add_step(OP_CYCLE, ADDR_CYCLE_CNT, 7, 6, 1'b0);
        add_step(OP_CYCLE, ADDR_CYCLE_CNT, 40, 39, 1'b0);
        add_step(OP_CLEAR, ADDR_RST_CNT, 0, 0, 1'b0);
        add_step(OP_EVENTS, 0, 50, 0, 1'b0);
        add_step(OP_READ, ADDR_INST_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_BR_INST_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_BR_SUC_CNT, 0, 0, 1'b1);
        add_step(OP_EVENTS, 0, 25, 0, 1'b0);
        add_step(OP_READ, ADDR_INST_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_BR_INST_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_BR_SUC_CNT, 0, 0, 1'b1);
        add_step(OP_READ, ADDR_CYCLE_CNT, 0, 0, 1'b1);
        add_step(OP_READ, 32'h8000_0020, 0, 32'h0, 1'b0);   // unmapped.
        add_step(OP_READ, 32'h0000_0000, 0, 32'h0, 1'b0);
        add_step(OP_IDLE, 0, 3, 0, 1'b0);
        add_step(OP_CLEAR, ADDR_RST_CNT, 0, 0, 1'b0);
        add_step(OP_READ, ADDR_UART_CTRL, 0, 32'h1, 1'b0);
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] rdata;
        logic [31:0] exp;
        logic [2:0]  pattern;
        case (s.op)
            OP_READ: begin
                exp = s.use_model ? model_value(s.addr) : s.expected;
                access(s.addr, 32'd0, rdata);
                check_value("dout", rdata, exp);
            end
            OP_WRITE_TX: begin
                poll_ctrl_bit(0);
                access(ADDR_UART_TDATA, s.arg, rdata);
                check_value("dout", rdata, 32'd0);
            end
            OP_CLEAR: begin
                access(ADDR_RST_CNT, 32'd0, rdata);
                check_value("dout", rdata, 32'd0);
            end
            OP_EVENTS: begin
                repeat (s.arg) begin
                    pattern = 3'($urandom_range(7));
                    events = pattern;
                    events.br_suc = events.br_suc & events.br_inst; // a hit needs a branch.
                    tick();
                end
                events = '0;
            end
            OP_WAIT_RX: begin
                poll_ctrl_bit(1);
                access(ADDR_UART_RDATA, 32'd0, rdata);
                check_value("dout", rdata, s.expected);
                tick(); // ack clears rx_valid one edge later.
                check_value("dout", dout, 32'd0);
                access(ADDR_UART_CTRL, 32'd0, rdata);
                check_value("dout[1] (rx_valid)", {31'b0, rdata[1]}, 32'd0);
            end
            OP_CYCLE: begin
                access(ADDR_RST_CNT, 32'd0, rdata);
                repeat (s.arg - 1) tick();
                access(ADDR_CYCLE_CNT, 32'd0, rdata);
                check_value("dout", rdata, s.expected);
            end
            OP_IDLE: begin
                repeat (s.arg) begin
                    tick();
                    check_value("dout", dout, 32'd0);
                end
            end
            default: ;
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence and timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        req    = '0;
        events = '0;
        void'($urandom(89843));
        build_table();
        foreach (steps[i]) begin
            cycle_limit += worst_cycles(steps[i]);
        end
        cycle_limit += 5;                 // reset edges.
        cycle_limit += cycle_limit / 5;   // 20% margin.
        wait (rst_n === 1'b1);
        model_cycles  = '0;
        model_inst    = '0;
        model_br_inst = '0;
        model_br_suc  = '0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1; // released just after the 4th edge.
    end

endmodule
